//--- tests/app_soc_testdata.txt
# test_name op address data strobes expected (hex)
# op: W write, R read and compare, P poll read until equal, L compare LED pins {r,g,b}
ram_strobe W 40000200 11223344 f 00000000
ram_strobe R 40000200 00000000 0 11223344
ram_strobe W 40000200 aabbccdd 1 00000000
ram_strobe R 40000200 00000000 0 112233dd
ram_strobe W 40000200 aabbccdd c 00000000
ram_strobe R 40000200 00000000 0 aabb33dd
ram_strobe W 40000204 01020304 f 00000000
ram_strobe W 40000204 a5a5a5a5 6 00000000
ram_strobe R 40000204 00000000 0 01a5a504
unmapped R 00000100 00000000 0 00000000
unmapped R 80000010 00000000 0 00000000
unmapped R c5000000 00000000 0 00000000
sys_ident R ff000000 00000000 0 61707073
sys_ident R ff000008 00000000 0 00000001
sys_led W ff000024 00000005 f 00000000
sys_led L 00000000 00000000 0 00000005
sys_led R ff000024 00000000 0 00000005
sys_led W ff000024 00000002 1 00000000
sys_led L 00000000 00000000 0 00000002
timer_run W c1000028 00000003 f 00000000
timer_run W c100002c 00000005 f 00000000
timer_run W c1000020 00000001 f 00000000
timer_run P c1000024 00000000 0 00000000
timer_run R c100002c 00000000 0 00000000
timer_stop W c100002c 00100000 f 00000000
timer_stop W c1000020 00000001 f 00000000
timer_stop R c1000024 00000000 0 00000001
timer_stop W c1000020 00000002 f 00000000
timer_stop R c1000024 00000000 0 00000000
app_mode W 40000040 cafef00d f 00000000
app_mode W 400000fc 0badf00d f 00000000
app_mode R 40000040 00000000 0 cafef00d
app_mode W ff000020 00000001 f 00000000
app_mode R 40000040 00000000 0 00000000
app_mode R 400000fc 00000000 0 00000000
app_mode W 40000040 12345678 f 00000000
app_mode R 40000040 00000000 0 00000000
app_mode W 40000100 87654321 f 00000000
app_mode R 40000100 00000000 0 87654321
app_mode R 40000200 00000000 0 aabb33dd
write_once W ff000020 00000000 f 00000000
write_once R ff000020 00000000 0 00000001
write_once R 40000040 00000000 0 00000000

//--- verilog.f
logic/soc_map_pkg.sv
logic/core_regs_pkg.sv
logic/core_bus_if.sv
logic/mem_ctrl.sv
logic/data_ram.sv
logic/timer_core.sv
logic/sys_ctrl.sv
logic/app_soc.sv
tests/app_soc_sva.sv
tests/app_soc_tb.sv

//--- Bender.yml
package:
  name: app_soc

sources:
  - logic/soc_map_pkg.sv
  - logic/core_regs_pkg.sv
  - logic/core_bus_if.sv
  - logic/mem_ctrl.sv
  - logic/data_ram.sv
  - logic/timer_core.sv
  - logic/sys_ctrl.sv
  - logic/app_soc.sv
  - target: test
    files:
      - tests/app_soc_sva.sv
      - tests/app_soc_tb.sv

//--- tests/app_soc_tb.sv
// --------------------
// Host accesses come from the data file, one per line, in file order.
// Lines that share a test name form one test. Every wait is bounded.
// --------------------
`timescale 1ns/1ps

module app_soc_tb;

  localparam int access_timeout = 20;
  localparam int poll_limit     = 200;

  logic        clk;
  logic        reset_n;
  logic        host_valid;
  logic [31:0] host_addr;
  logic [31:0] host_wdata;
  logic [3:0]  host_wstrb;
  logic        host_ready;
  logic [31:0] host_rdata;
  logic        led_r;
  logic        led_g;
  logic        led_b;

  int errors;
  int test_errors;
  int tests_run;
  int tests_failed;

  app_soc i_dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .host_valid (host_valid),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_wstrb (host_wstrb),
    .host_ready (host_ready),
    .host_rdata (host_rdata),
    .led_r      (led_r),
    .led_g      (led_g),
    .led_b      (led_b)
  );

  always #50 clk = ~clk;

  // One access, entered and left on a falling edge
  task automatic host_access(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb, output logic [31:0] rdata,
                             output bit done);
    int cycles;
    cycles     = 0;
    done       = 1'b0;
    host_valid = 1'b1;
    host_addr  = addr;
    host_wdata = wdata;
    host_wstrb = wstrb;
    while (!done && cycles < access_timeout) begin
      @(negedge clk);
      cycles++;
      done = host_ready;
    end
    rdata      = host_rdata;
    host_valid = 1'b0;
    host_wstrb = 4'h0;
    if (!done) begin
      $display("Timeout at %0t: no host_ready within %0d cycles for address %h",
               $time, access_timeout, addr);
      test_errors++;
    end
  endtask

  task automatic report_test(input logic [8*24-1:0] name, input int ops);
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
      $display("test %0s: failed, %0d errors in %0d operations", name, test_errors, ops);
    end else begin
      $display("test %0s: ok, %0d operations", name, ops);
    end
    errors      += test_errors;
    test_errors = 0;
  endtask

  initial begin : main
    int              fd;
    int              fields;
    int              ops;
    int              polls;
    string           line;
    logic [8*24-1:0] name;
    logic [8*24-1:0] cur_name;
    logic [7:0]      op;
    logic [31:0]     addr;
    logic [31:0]     data;
    logic [31:0]     expected;
    logic [31:0]     rdata;
    logic [3:0]      strb;
    bit              done;
    bit              matched;

    clk          = 1'b0;
    reset_n      = 1'b0;
    host_valid   = 1'b0;
    host_addr    = 32'h0;
    host_wdata   = 32'h0;
    host_wstrb   = 4'h0;
    errors       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    cur_name     = '0;
    ops          = 0;

    repeat (8) @(negedge clk);
    reset_n = 1'b1;

    // State right after reset
    if (host_ready !== 1'b0) begin
      $display("CHECK FAILED at %0t: host_ready expected 0, actual %b", $time, host_ready);
      test_errors++;
    end
    if ({led_r, led_g, led_b} !== 3'b000) begin
      $display("CHECK FAILED at %0t: led_rgb expected 000, actual %b", $time,
               {led_r, led_g, led_b});
      test_errors++;
    end
    report_test("reset", 2);

    fd = $fopen("tests/app_soc_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open tests/app_soc_testdata.txt, no data-driven tests were run");
      errors++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() < 2 || line[0] == "#") begin
          continue;
        end
        fields = $sscanf(line, "%s %s %h %h %h %h", name, op, addr, data, strb, expected);
        if (fields != 6) begin
          $display("Malformed line in test data, only %0d fields: %s", fields, line);
          errors++;
          continue;
        end
        if (name != cur_name) begin
          if (ops != 0) begin
            report_test(cur_name, ops);
          end
          cur_name = name;
          ops      = 0;
        end
        ops++;

        case (op)
          "W": host_access(addr, data, strb, rdata, done);
          "R": begin
            host_access(addr, 32'h0, 4'h0, rdata, done);
            if (done && rdata !== expected) begin
              $display("CHECK FAILED at %0t: host_rdata expected %h, actual %h (address %h)",
                       $time, expected, rdata, addr);
              test_errors++;
            end
          end
          "P": begin
            matched = 1'b0;
            done    = 1'b1;
            polls   = 0;
            while (!matched && done && polls < poll_limit) begin
              host_access(addr, 32'h0, 4'h0, rdata, done);
              polls++;
              matched = done && (rdata === expected);
            end
            if (done && !matched) begin
              $display("Poll timeout at %0t: address %h never read %h in %0d reads",
                       $time, addr, expected, poll_limit);
              test_errors++;
            end
          end
          "L": begin
            if ({led_r, led_g, led_b} !== expected[2:0]) begin
              $display("CHECK FAILED at %0t: led_rgb expected %b, actual %b", $time,
                       expected[2:0], {led_r, led_g, led_b});
              test_errors++;
            end
          end
          default: begin
            $display("Unknown operation code %s in test %0s", op, name);
            test_errors++;
          end
        endcase
      end
      if (ops != 0) begin
        report_test(cur_name, ops);
      end
      $fclose(fd);
    end

    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- tests/app_soc_sva.sv
// --------------------
// Host handshake and core select rules, checked out of reset only.
// Bound into mem_ctrl.
// --------------------
`timescale 1ns/1ps

module app_soc_sva (
  input logic clk,
  input logic reset_n,
  input logic host_ready,
  input logic ram_cs,
  input logic timer_cs,
  input logic ctrl_cs
);

  logic [2:0] cs_all;

  assign cs_all = {ram_cs, timer_cs, ctrl_cs};

  // At most one core selected
  one_cs: assert property (@(posedge clk) disable iff (!reset_n) $onehot0(cs_all))
    else $error("more than one core select is high");

  // Response is a single pulse
  ready_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    host_ready |=> !host_ready)
    else $error("host_ready stayed high for two cycles");

  // Selects drop while the response is presented
  no_cs_on_ready: assert property (@(posedge clk) disable iff (!reset_n)
    host_ready |-> (cs_all == 3'b000))
    else $error("core select high while host_ready is high");

endmodule

bind mem_ctrl app_soc_sva i_app_soc_sva (
  .clk        (clk),
  .reset_n    (reset_n),
  .host_ready (host_ready),
  .ram_cs     (ram_bus.cs),
  .timer_cs   (timer_bus.cs),
  .ctrl_cs    (ctrl_bus.cs)
);

//--- logic/app_soc.sv
// --------------------
// Subsystem top. The host port takes one valid/ready access at a
// time; a nonzero strobe makes it a write.
// --------------------
`timescale 1ns/1ps

module app_soc (
  input  logic                           clk,
  input  logic                           reset_n,
  input  logic                           host_valid,
  input  logic [soc_map_pkg::addr_w-1:0] host_addr,
  input  logic [soc_map_pkg::data_w-1:0] host_wdata,
  input  logic [soc_map_pkg::strb_w-1:0] host_wstrb,
  output logic                           host_ready,
  output logic [soc_map_pkg::data_w-1:0] host_rdata,
  output logic                           led_r,
  output logic                           led_g,
  output logic                           led_b
);

  logic app_mode;

  // One bus per core
  core_bus_if ram_bus ();
  core_bus_if timer_bus ();
  core_bus_if ctrl_bus ();

  mem_ctrl i_mem_ctrl (
    .clk        (clk),
    .reset_n    (reset_n),
    .host_valid (host_valid),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_wstrb (host_wstrb),
    .host_ready (host_ready),
    .host_rdata (host_rdata),
    .ram_bus    (ram_bus.ctrl),
    .timer_bus  (timer_bus.ctrl),
    .ctrl_bus   (ctrl_bus.ctrl)
  );

  data_ram i_data_ram (
    .clk      (clk),
    .reset_n  (reset_n),
    .app_mode (app_mode),
    .bus      (ram_bus.core)
  );

  timer_core i_timer_core (
    .clk     (clk),
    .reset_n (reset_n),
    .bus     (timer_bus.core)
  );

  sys_ctrl i_sys_ctrl (
    .clk      (clk),
    .reset_n  (reset_n),
    .bus      (ctrl_bus.core),
    .app_mode (app_mode),
    .led_r    (led_r),
    .led_g    (led_g),
    .led_b    (led_b)
  );

endmodule

//--- logic/sys_ctrl.sv
// --------------------
// System control. Application mode is set by any write to its
// register and only reset clears it.
// --------------------
`timescale 1ns/1ps

module sys_ctrl (
  input  logic     clk,
  input  logic     reset_n,
  core_bus_if.core bus,
  output logic     app_mode,
  output logic     led_r,
  output logic     led_g,
  output logic     led_b
);

  logic [2:0]                     led;
  logic [soc_map_pkg::data_w-1:0] rdata_new;
  logic                           wr_en;

  assign wr_en = bus.cs && (|bus.we);

  // --------------------
  // Control registers
  // --------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      app_mode  <= 1'b0;
      led       <= 3'b000;
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= bus.cs;

      // Write-once, the data value is ignored
      if (wr_en && (bus.address == core_regs_pkg::ADDR_APP_MODE)) begin
        app_mode <= 1'b1;
      end
      if (wr_en && (bus.address == core_regs_pkg::ADDR_LED)) begin
        led <= bus.write_data[2:0];
      end
    end
  end

  assign led_r = led[2];
  assign led_g = led[1];
  assign led_b = led[0];

  // --------------------
  // Read mux
  // --------------------
  always_comb begin
    rdata_new = '0;
    case (bus.address)
      core_regs_pkg::ADDR_NAME:     rdata_new      = core_regs_pkg::CORE_NAME;
      core_regs_pkg::ADDR_VERSION:  rdata_new      = core_regs_pkg::CORE_VERSION;
      core_regs_pkg::ADDR_APP_MODE: rdata_new[0]   = app_mode;
      core_regs_pkg::ADDR_LED:      rdata_new[2:0] = led;
      default:                      rdata_new      = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (bus.cs) begin
      bus.read_data <= rdata_new;
    end
  end

endmodule

//--- logic/timer_core.sv
// --------------------
// Countdown timer. The counter loads from the value register on start
// and steps down once every prescaler+1 cycles until it reaches zero.
// --------------------
`timescale 1ns/1ps

module timer_core (
  input  logic     clk,
  input  logic     reset_n,
  core_bus_if.core bus
);

  core_regs_pkg::timer_state_e    state;
  logic [soc_map_pkg::data_w-1:0] prescaler;
  logic [soc_map_pkg::data_w-1:0] value;
  logic [soc_map_pkg::data_w-1:0] counter;
  logic [soc_map_pkg::data_w-1:0] presc_cnt;
  logic [soc_map_pkg::data_w-1:0] rdata_new;
  logic                           cs_reg;
  logic                           wr_en;
  logic                           first_wr;
  logic                           start;
  logic                           stop;

  assign wr_en    = bus.cs && (|bus.we);
  // Held writes repeat, control pulses fire once
  assign first_wr = wr_en && !cs_reg;
  assign start    = first_wr && (bus.address == core_regs_pkg::ADDR_TIMER_CTRL) &&
                    bus.write_data[0];
  assign stop     = first_wr && (bus.address == core_regs_pkg::ADDR_TIMER_CTRL) &&
                    bus.write_data[1];

  // --------------------
  // Registers and countdown
  // --------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state     <= core_regs_pkg::TIMER_IDLE;
      prescaler <= '0;
      value     <= '0;
      counter   <= '0;
      presc_cnt <= '0;
      cs_reg    <= 1'b0;
      bus.ready <= 1'b0;
    end else begin
      cs_reg    <= bus.cs;
      bus.ready <= bus.cs;

      if (wr_en && (bus.address == core_regs_pkg::ADDR_TIMER_PRESCALER)) begin
        prescaler <= bus.write_data;
      end
      if (wr_en && (bus.address == core_regs_pkg::ADDR_TIMER_VALUE)) begin
        value <= bus.write_data;
      end

      // Stop wins over start
      if (stop) begin
        state <= core_regs_pkg::TIMER_IDLE;
      end else if (start) begin
        state     <= core_regs_pkg::TIMER_RUN;
        counter   <= value;
        presc_cnt <= '0;
      end else if (state == core_regs_pkg::TIMER_RUN) begin
        if (counter == '0) begin
          state <= core_regs_pkg::TIMER_IDLE;
        end else if (presc_cnt == prescaler) begin
          presc_cnt <= '0;
          counter   <= counter - 1'b1;
        end else begin
          presc_cnt <= presc_cnt + 1'b1;
        end
      end
    end
  end

  // --------------------
  // Read mux
  // --------------------
  always_comb begin
    rdata_new = '0;
    case (bus.address)
      core_regs_pkg::ADDR_TIMER_STATUS:    rdata_new[0] = (state == core_regs_pkg::TIMER_RUN);
      core_regs_pkg::ADDR_TIMER_PRESCALER: rdata_new    = prescaler;
      core_regs_pkg::ADDR_TIMER_VALUE:     rdata_new    = counter;
      default:                             rdata_new    = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (bus.cs) begin
      bus.read_data <= rdata_new;
    end
  end

endmodule

//--- logic/data_ram.sv
// --------------------
// Word RAM with byte strobes and one cycle read latency. In
// application mode the firmware words read zero and ignore writes.
// --------------------
`timescale 1ns/1ps

module data_ram (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     app_mode,
  core_bus_if.core bus
);

  logic [soc_map_pkg::data_w-1:0] mem [soc_map_pkg::ram_words];
  logic                           hidden;

  // Firmware region lookup
  assign hidden = app_mode &&
                  (bus.address < soc_map_pkg::core_addr_w'(soc_map_pkg::fw_region_words));

  // Byte lane writes
  always_ff @(posedge clk) begin
    for (int i = 0; i < soc_map_pkg::strb_w; i++) begin
      if (bus.cs && bus.we[i] && !hidden) begin
        mem[bus.address][8*i +: 8] <= bus.write_data[8*i +: 8];
      end
    end
  end

  // Read data returned with ready
  always_ff @(posedge clk) begin
    if (bus.cs) begin
      bus.read_data <= hidden ? '0 : mem[bus.address];
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= bus.cs;
    end
  end

endmodule

//--- logic/mem_ctrl.sv
// --------------------
// Host access decoder. One access outstanding at a time; the host must
// hold its request until host_ready. Unmapped areas and core prefixes
// complete after one cycle with zero data.
// --------------------
`timescale 1ns/1ps

module mem_ctrl (
  input  logic                           clk,
  input  logic                           reset_n,
  input  logic                           host_valid,
  input  logic [soc_map_pkg::addr_w-1:0] host_addr,
  input  logic [soc_map_pkg::data_w-1:0] host_wdata,
  input  logic [soc_map_pkg::strb_w-1:0] host_wstrb,
  output logic                           host_ready,
  output logic [soc_map_pkg::data_w-1:0] host_rdata,
  core_bus_if.ctrl                       ram_bus,
  core_bus_if.ctrl                       timer_bus,
  core_bus_if.ctrl                       ctrl_bus
);

  soc_map_pkg::area_e                  area;
  soc_map_pkg::core_e                  core;
  logic [soc_map_pkg::core_addr_w-1:0] reg_addr;
  logic [soc_map_pkg::data_w-1:0]      rdata_new;
  logic                                ready_new;

  // --------------------
  // Address split
  // --------------------
  assign area     = soc_map_pkg::area_e'(host_addr[soc_map_pkg::area_hi:soc_map_pkg::area_lo]);
  assign core     = soc_map_pkg::core_e'(host_addr[soc_map_pkg::core_hi:soc_map_pkg::core_lo]);
  assign reg_addr = host_addr[soc_map_pkg::reg_hi:soc_map_pkg::reg_lo];

  // Address, data and strobes go to every core, only cs differs
  assign ram_bus.address      = reg_addr;
  assign ram_bus.write_data   = host_wdata;
  assign ram_bus.we           = host_wstrb;

  assign timer_bus.address    = reg_addr;
  assign timer_bus.write_data = host_wdata;
  assign timer_bus.we         = host_wstrb;

  assign ctrl_bus.address     = reg_addr;
  assign ctrl_bus.write_data  = host_wdata;
  assign ctrl_bus.we          = host_wstrb;

  // --------------------
  // Core select and response mux
  // --------------------
  always_comb begin
    ram_bus.cs   = 1'b0;
    timer_bus.cs = 1'b0;
    ctrl_bus.cs  = 1'b0;
    rdata_new    = '0;
    ready_new    = 1'b0;

    // Selects drop while the response is presented
    if (host_valid && !host_ready) begin
      case (area)
        soc_map_pkg::AREA_RAM: begin
          ram_bus.cs = 1'b1;
          rdata_new  = ram_bus.read_data;
          ready_new  = ram_bus.ready;
        end

        soc_map_pkg::AREA_MMIO: begin
          case (core)
            soc_map_pkg::CORE_TIMER: begin
              timer_bus.cs = 1'b1;
              rdata_new    = timer_bus.read_data;
              ready_new    = timer_bus.ready;
            end

            soc_map_pkg::CORE_SYS_CTRL: begin
              ctrl_bus.cs = 1'b1;
              rdata_new   = ctrl_bus.read_data;
              ready_new   = ctrl_bus.ready;
            end

            // Empty MMIO slot
            default: begin
              ready_new = 1'b1;
            end
          endcase
        end

        // No ROM in this subsystem
        soc_map_pkg::AREA_ROM, soc_map_pkg::AREA_RESERVED: begin
          ready_new = 1'b1;
        end
      endcase
    end
  end

  // --------------------
  // Registered host response
  // --------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      host_ready <= 1'b0;
    end else begin
      host_ready <= ready_new;
    end
  end

  always_ff @(posedge clk) begin
    host_rdata <= rdata_new;
  end

endmodule

//--- logic/core_bus_if.sv
// --------------------
// Chip-select bus from the decoder to one core. The core answers with
// ready one cycle after cs. we carries byte strobes; non-RAM cores
// treat any set bit as a write.
// --------------------
`timescale 1ns/1ps

interface core_bus_if;

  logic                                cs;
  logic [soc_map_pkg::strb_w-1:0]      we;
  logic [soc_map_pkg::core_addr_w-1:0] address;
  logic [soc_map_pkg::data_w-1:0]      write_data;
  logic [soc_map_pkg::data_w-1:0]      read_data;
  logic                                ready;

  // Decoder side
  modport ctrl (output cs, we, address, write_data, input read_data, ready);

  // Core side
  modport core (input cs, we, address, write_data, output read_data, ready);

endinterface

//--- logic/core_regs_pkg.sv
// --------------------
// Register offsets of the timer and system control cores, in words.
// Offsets not listed here read as zero.
// --------------------

package core_regs_pkg;

  // --------------------
  // Timer
  // --------------------
  // Ctrl bit 0 start, bit 1 stop, both pulses
  localparam logic [soc_map_pkg::core_addr_w-1:0] ADDR_TIMER_CTRL      = 8'h08;
  // Status bit 0 running
  localparam logic [soc_map_pkg::core_addr_w-1:0] ADDR_TIMER_STATUS    = 8'h09;
  localparam logic [soc_map_pkg::core_addr_w-1:0] ADDR_TIMER_PRESCALER = 8'h0a;
  localparam logic [soc_map_pkg::core_addr_w-1:0] ADDR_TIMER_VALUE     = 8'h0b;

  typedef enum logic {
    TIMER_IDLE = 1'b0,
    TIMER_RUN  = 1'b1
  } timer_state_e;

  // --------------------
  // System control
  // --------------------
  localparam logic [soc_map_pkg::core_addr_w-1:0] ADDR_NAME     = 8'h00;
  localparam logic [soc_map_pkg::core_addr_w-1:0] ADDR_VERSION  = 8'h02;
  localparam logic [soc_map_pkg::core_addr_w-1:0] ADDR_APP_MODE = 8'h08;
  // LED bits 2:0 are r, g, b
  localparam logic [soc_map_pkg::core_addr_w-1:0] ADDR_LED      = 8'h09;

  // Identity, "apps" in ASCII
  localparam logic [soc_map_pkg::data_w-1:0] CORE_NAME    = 32'h6170_7073;
  localparam logic [soc_map_pkg::data_w-1:0] CORE_VERSION = 32'h0000_0001;

endpackage

//--- logic/soc_map_pkg.sv
// --------------------
// Address map of the subsystem. Sizes are fixed here and are not set
// per instance. Only the timer and system control answer inside MMIO.
// --------------------

package soc_map_pkg;

  // Host word and strobe widths
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = 4;

  // Core register address, taken from the word address bits
  localparam int core_addr_w = 8;
  localparam int reg_lo      = 2;
  localparam int reg_hi      = reg_lo + core_addr_w - 1;

  // --------------------
  // Prefix fields
  // --------------------
  localparam int area_hi = 31;
  localparam int area_lo = 30;
  localparam int core_hi = 29;
  localparam int core_lo = 24;

  typedef enum logic [1:0] {
    AREA_ROM      = 2'h0,
    AREA_RAM      = 2'h1,
    AREA_RESERVED = 2'h2,
    AREA_MMIO     = 2'h3
  } area_e;

  // Core prefixes inside the MMIO area
  typedef enum logic [5:0] {
    CORE_TIMER    = 6'h01,
    CORE_SYS_CTRL = 6'h3f
  } core_e;

  // RAM size, lowest words hold firmware
  localparam int ram_words       = 256;
  localparam int fw_region_words = 64;

endpackage
